//--- hw/gat_attn_defs.svh
// ====================
// Sizing for the GAT attention-coefficient stage.
// Included by the package and every RTL file. The feature count
// must stay a power of two and GAT_TREE_STAGES must track it.
// ====================

`ifndef GAT_ATTN_DEFS_SVH
`define GAT_ATTN_DEFS_SVH

// Features per WH row, power of two only
`define GAT_NUM_FEAT     8

// Element widths, both signed
`define GAT_DATA_W       8
`define GAT_WH_W         12

// 20-bit products, 8 of them summed
`define GAT_SUM_W        23
`define GAT_NODE_W       8

// Coefficient scaling and buffering
`define GAT_COEF_SHIFT   6
`define GAT_FIFO_DEPTH   16

// Multiply stage plus log2(GAT_NUM_FEAT) adder levels
`define GAT_TREE_STAGES  4

`endif

//--- hw/gat_attn_pkg.sv
// ====================
// Shared types for the attention-coefficient stage.
// Referenced by scoped name from the RTL and testbench.
// ====================

`include "gat_attn_defs.svh"

package gat_attn_pkg;

  // Single elements, interpreted as signed where used
  typedef logic [`GAT_DATA_W-1:0] attn_elem_t;
  typedef logic [`GAT_WH_W-1:0]   wh_elem_t;

  // One half of the attention vector
  // Element i of a loaded half weights WH feature N-1-i
  typedef attn_elem_t [`GAT_NUM_FEAT-1:0] attn_vec_t;

  // Full vector as loaded, source half in the upper field
  typedef struct packed {
    attn_vec_t src;
    attn_vec_t nbr;
  } attn_full_t;

  // Feature k of a row sits in feat[k]
  typedef wh_elem_t [`GAT_NUM_FEAT-1:0] wh_feat_t;

  typedef struct packed {
    wh_feat_t                feat;
    logic [`GAT_NODE_W-1:0]  num_node;
    logic                    src_flag;
  } wh_row_t;

  // Row info that rides alongside the dot-product tree
  typedef struct packed {
    logic                    src_flag;
    logic [`GAT_NODE_W-1:0]  num_node;
  } wh_tag_t;

  typedef logic [7:0] coef_t;

endpackage

//--- hw/attn_weight_reg.sv
// ====================
// Attention weight holding register.
// Captures the full vector on a_load_i and presents the source and
// neighbor halves with element order flipped to match the WH rows.
// ====================

`timescale 1ns/1ps

`include "gat_attn_defs.svh"

module attn_weight_reg (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    a_load_i,
  input  gat_attn_pkg::attn_full_t a_i,
  output gat_attn_pkg::attn_vec_t  a_src_o,
  output gat_attn_pkg::attn_vec_t  a_nbr_o
);

  localparam int N = `GAT_NUM_FEAT;

  gat_attn_pkg::attn_full_t a_q;

  // Load only between neighborhoods, never with rows in flight
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      a_q <= '0;
    end else if (a_load_i) begin
      a_q <= a_i;
    end
  end

  // ====================
  // Half split and flip
  // ====================

  genvar k;
  generate
    for (k = 0; k < N; k++) begin : g_flip
      // Index k now pairs with feat[k]
      assign a_src_o[k] = a_q.src[N-1-k];
      assign a_nbr_o[k] = a_q.nbr[N-1-k];
    end
  endgenerate

endmodule

//--- hw/dot_tree.sv
// ====================
// Pipelined signed dot product.
// Level 0 registers the element products, each later level registers
// pairwise sums. Latency is GAT_TREE_STAGES, one row per cycle,
// with a valid bit and a row tag carried level by level.
// ====================

`timescale 1ns/1ps

`include "gat_attn_defs.svh"

module dot_tree (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          vld_i,
  input  gat_attn_pkg::attn_vec_t       w_i,
  input  gat_attn_pkg::wh_feat_t        x_i,
  input  gat_attn_pkg::wh_tag_t         tag_i,
  output logic                          vld_o,
  output logic signed [`GAT_SUM_W-1:0]  sum_o,
  output gat_attn_pkg::wh_tag_t         tag_o
);

  localparam int N      = `GAT_NUM_FEAT;
  localparam int SUM_W  = `GAT_SUM_W;
  localparam int STAGES = `GAT_TREE_STAGES;

  genvar s, k;
  generate
    for (s = 0; s < STAGES; s++) begin : g_lvl
      // Level s keeps N >> s partial sums
      localparam int W = N >> s;

      logic [W-1:0][SUM_W-1:0] sum_q;
      logic                    vld_q;
      gat_attn_pkg::wh_tag_t   tag_q;

      if (s == 0) begin : g_mul
        // Signed products, sign extended to the full sum width
        always_ff @(posedge clk) begin
          for (int i = 0; i < W; i++) begin
            sum_q[i] <= $signed(w_i[i]) * $signed(x_i[i]);
          end
        end

        always_ff @(posedge clk or negedge rst_n) begin
          if (!rst_n) begin
            vld_q <= 1'b0;
            tag_q <= '0;
          end else begin
            vld_q <= vld_i;
            tag_q <= tag_i;
          end
        end
      end else begin : g_add
        for (k = 0; k < W; k++) begin : g_pair
          always_ff @(posedge clk) begin
            sum_q[k] <= g_lvl[s-1].sum_q[2*k] + g_lvl[s-1].sum_q[2*k+1];
          end
        end

        always_ff @(posedge clk or negedge rst_n) begin
          if (!rst_n) begin
            vld_q <= 1'b0;
            tag_q <= '0;
          end else begin
            vld_q <= g_lvl[s-1].vld_q;
            tag_q <= g_lvl[s-1].tag_q;
          end
        end
      end
    end
  endgenerate

  // Last level holds a single sum
  assign vld_o = g_lvl[STAGES-1].vld_q;
  assign sum_o = g_lvl[STAGES-1].sum_q[0];
  assign tag_o = g_lvl[STAGES-1].tag_q;

endmodule

//--- hw/dmvm.sv
// ====================
// Attention coefficient datapath.
// Registers each WH row, runs the source and neighbor dot products,
// holds the source sum per neighborhood and writes
// sat8((ReLU(src + nbr)) >> GAT_COEF_SHIFT) six cycles after the row.
// ====================

`timescale 1ns/1ps

`include "gat_attn_defs.svh"

module dmvm (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     wh_vld_i,
  input  gat_attn_pkg::wh_row_t    wh_i,
  input  gat_attn_pkg::attn_vec_t  a_src_i,
  input  gat_attn_pkg::attn_vec_t  a_nbr_i,
  output logic                     coef_wr_o,
  output gat_attn_pkg::coef_t      coef_o
);

  localparam int SUM_W = `GAT_SUM_W;

  gat_attn_pkg::wh_row_t   row_q;
  logic                    row_vld_q;
  gat_attn_pkg::wh_tag_t   row_tag;

  logic                    src_vld;
  logic signed [SUM_W-1:0] src_sum;
  logic signed [SUM_W-1:0] nbr_sum;
  gat_attn_pkg::wh_tag_t   src_tag;

  logic signed [SUM_W-1:0] src_hold_q;
  logic signed [SUM_W-1:0] src_cur;
  logic signed [SUM_W:0]   comb_sum;
  logic        [SUM_W:0]   shifted;
  gat_attn_pkg::coef_t     coef_d;

  // ====================
  // Input register
  // ====================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      row_vld_q <= 1'b0;
    end else begin
      row_vld_q <= wh_vld_i;
    end
  end

  always_ff @(posedge clk) begin
    row_q <= wh_i;
  end

  assign row_tag.src_flag = row_q.src_flag;
  assign row_tag.num_node = row_q.num_node;

  // Source tree carries the row tag and the valid
  dot_tree u_src_tree (
    .clk   (clk),
    .rst_n (rst_n),
    .vld_i (row_vld_q),
    .w_i   (a_src_i),
    .x_i   (row_q.feat),
    .tag_i (row_tag),
    .vld_o (src_vld),
    .sum_o (src_sum),
    .tag_o (src_tag)
  );

  // Runs in lockstep, so its own valid and tag are not needed
  dot_tree u_nbr_tree (
    .clk   (clk),
    .rst_n (rst_n),
    .vld_i (row_vld_q),
    .w_i   (a_nbr_i),
    .x_i   (row_q.feat),
    .tag_i ('0),
    .vld_o (),
    .sum_o (nbr_sum),
    .tag_o ()
  );

  // ====================
  // Source hold
  // ====================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      src_hold_q <= '0;
    end else if (src_vld && src_tag.src_flag) begin
      src_hold_q <= src_sum;
    end
  end

  // Flagged row uses its own fresh sum
  assign src_cur = src_tag.src_flag ? src_sum : src_hold_q;

  // ====================
  // ReLU, shift, saturate
  // ====================

  always_comb begin
    comb_sum = src_cur + nbr_sum;
    shifted  = comb_sum >> `GAT_COEF_SHIFT;
    if (comb_sum[SUM_W]) begin
      coef_d = '0;
    end else if (|shifted[SUM_W:8]) begin
      coef_d = 8'hff;
    end else begin
      coef_d = shifted[7:0];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      coef_wr_o <= 1'b0;
    end else begin
      coef_wr_o <= src_vld;
    end
  end

  always_ff @(posedge clk) begin
    coef_o <= coef_d;
  end

endmodule

//--- hw/coef_fifo.sv
// ====================
// Show-ahead coefficient FIFO.
// Head entry is always on dout_o while vld_o is high. A write into a
// full FIFO is dropped and latches overflow_o until reset, unless a
// pop in the same cycle frees the slot.
// ====================

`timescale 1ns/1ps

`include "gat_attn_defs.svh"

module coef_fifo (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 wr_i,
  input  gat_attn_pkg::coef_t  din_i,
  input  logic                 pop_i,
  output gat_attn_pkg::coef_t  dout_o,
  output logic                 vld_o,
  output logic                 overflow_o
);

  // Depth is a power of two so the pointers wrap on their own
  localparam int DEPTH = `GAT_FIFO_DEPTH;
  localparam int AW    = $clog2(DEPTH);

  gat_attn_pkg::coef_t mem [DEPTH];
  logic [AW-1:0]       wr_ptr_q;
  logic [AW-1:0]       rd_ptr_q;
  logic [AW:0]         count_q;
  logic                full;
  logic                do_pop;
  logic                do_wr;

  assign full   = (count_q == (AW+1)'(DEPTH));
  assign do_pop = pop_i && vld_o;
  assign do_wr  = wr_i && (!full || do_pop);

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr_q] <= din_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      overflow_o <= 1'b0;
    end else begin
      if (do_wr) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (do_pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({do_wr, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
      // Sticky drop flag
      if (wr_i && !do_wr) overflow_o <= 1'b1;
    end
  end

  assign vld_o  = (count_q != '0);
  assign dout_o = mem[rd_ptr_q];

endmodule

//--- hw/gat_attn_top.sv
// ====================
// GAT attention-coefficient stage, top level.
// Weight register feeds the dot-product datapath, whose coefficients
// land in the show-ahead FIFO seven cycles after the row strobe.
// ====================

`timescale 1ns/1ps

`include "gat_attn_defs.svh"

module gat_attn_top (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      a_load_i,
  input  gat_attn_pkg::attn_full_t  a_i,
  input  logic                      wh_vld_i,
  input  gat_attn_pkg::wh_row_t     wh_i,
  input  logic                      pop_i,
  output gat_attn_pkg::coef_t       coef_o,
  output logic                      coef_vld_o,
  output logic                      overflow_o
);

  gat_attn_pkg::attn_vec_t a_src;
  gat_attn_pkg::attn_vec_t a_nbr;
  logic                    coef_wr;
  gat_attn_pkg::coef_t     coef_din;

  attn_weight_reg u_weight (
    .clk      (clk),
    .rst_n    (rst_n),
    .a_load_i (a_load_i),
    .a_i      (a_i),
    .a_src_o  (a_src),
    .a_nbr_o  (a_nbr)
  );

  dmvm u_dmvm (
    .clk       (clk),
    .rst_n     (rst_n),
    .wh_vld_i  (wh_vld_i),
    .wh_i      (wh_i),
    .a_src_i   (a_src),
    .a_nbr_i   (a_nbr),
    .coef_wr_o (coef_wr),
    .coef_o    (coef_din)
  );

  coef_fifo u_fifo (
    .clk        (clk),
    .rst_n      (rst_n),
    .wr_i       (coef_wr),
    .din_i      (coef_din),
    .pop_i      (pop_i),
    .dout_o     (coef_o),
    .vld_o      (coef_vld_o),
    .overflow_o (overflow_o)
  );

endmodule

//--- verif/attn_checker.sv
// ====================
// Scoreboard for the GAT attention testbench.
// Collects the expected coefficients from the golden file, then scores
// every pop of the DUT FIFO and every requested overflow check.
// ====================

`timescale 1ns/1ps

module attn_checker (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 pop_i,
  input  gat_attn_pkg::coef_t  coef_i,
  input  logic                 coef_vld_i,
  input  logic                 overflow_i,
  input  logic                 ovf_chk_i,
  input  logic                 ovf_exp_i,
  output int                   pop_cnt_o,
  output int                   err_cnt_o
);

  int exp_q [$];
  int exp_v;
  int pops     = 0;
  int errs     = 0;
  bit load_err = 1'b0;

  assign pop_cnt_o = pops;
  assign err_cnt_o = errs + int'(load_err);

  // ====================
  // Expected values
  // ====================

  initial begin : load_expected
    int    fd;
    int    n;
    int    flag;
    int    nn;
    int    ex;
    int    f [8];
    string line;
    fd = $fopen("verif/gat_attn_golden.txt", "r");
    if (fd == 0) begin
      $display("Checker could not open the golden file");
      load_err = 1'b1;
    end else begin
      while ($fgets(line, fd) != 0) begin
        n = $sscanf(line, "R %d %d %d %d %d %d %d %d %d %d %d", flag, nn,
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], ex);
        // Dropped rows carry -1 and never reach the output
        if (n == 11 && ex >= 0) begin
          exp_q.push_back(ex);
        end
      end
      $fclose(fd);
    end
  end

  // ====================
  // Compare
  // ====================

  // Mid-cycle, pop_i and the FIFO head are both settled
  always @(negedge clk) begin
    if (rst_n) begin
      if (pop_i && coef_vld_i) begin
        pops++;
        if (exp_q.size() == 0) begin
          $display("At %0t ns coefficient %0d was popped with nothing left to expect",
                   $time, coef_i);
          errs++;
        end else begin
          exp_v = exp_q.pop_front();
          if (coef_i !== exp_v[7:0]) begin
            $display("Mismatch at %0t ns: coef_o is %0d, expected %0d", $time, coef_i, exp_v);
            errs++;
          end
        end
      end
      if (ovf_chk_i && (overflow_i !== ovf_exp_i)) begin
        $display("Mismatch at %0t ns: overflow_o is %0b, expected %0b",
                 $time, overflow_i, ovf_exp_i);
        errs++;
      end
    end
  end

endmodule

//--- verif/tb_gat_attn.sv
// ====================
// Testbench for the GAT attention-coefficient stage.
// Replays the golden file phase by phase with weight loads, WH rows
// and FIFO drains that use random pop gaps. attn_checker scores each pop.
// ====================

`timescale 1ns/1ps

`include "gat_attn_defs.svh"

module tb_gat_attn;

  localparam int N             = `GAT_NUM_FEAT;
  localparam int DRAIN_TIMEOUT = 400;
  // Row strobe to visible FIFO head
  localparam int FILL_LATENCY  = 7;

  logic                      clk;
  logic                      rst_n;
  logic                      a_load_i;
  gat_attn_pkg::attn_full_t  a_i;
  logic                      wh_vld_i;
  gat_attn_pkg::wh_row_t     wh_i;
  logic                      pop_i;
  gat_attn_pkg::coef_t       coef_o;
  logic                      coef_vld_o;
  logic                      overflow_o;

  logic                      ovf_chk;
  logic                      ovf_exp;
  int                        pop_cnt;
  int                        chk_errors;
  int                        tb_errors;
  int                        exp_total;
  bit                        timed_out;
  int                        w_buf [2*N];
  gat_attn_pkg::wh_row_t     row_q [$];

  gat_attn_top uut (
    .clk        (clk),
    .rst_n      (rst_n),
    .a_load_i   (a_load_i),
    .a_i        (a_i),
    .wh_vld_i   (wh_vld_i),
    .wh_i       (wh_i),
    .pop_i      (pop_i),
    .coef_o     (coef_o),
    .coef_vld_o (coef_vld_o),
    .overflow_o (overflow_o)
  );

  attn_checker chk (
    .clk        (clk),
    .rst_n      (rst_n),
    .pop_i      (pop_i),
    .coef_i     (coef_o),
    .coef_vld_i (coef_vld_o),
    .overflow_i (overflow_o),
    .ovf_chk_i  (ovf_chk),
    .ovf_exp_i  (ovf_exp),
    .pop_cnt_o  (pop_cnt),
    .err_cnt_o  (chk_errors)
  );

  always #50 clk = ~clk;

  // ====================
  // Driver tasks
  // ====================

  // Inputs change 5 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #5;
  endtask

  task automatic load_weights();
    for (int k = 0; k < N; k++) begin
      // Element 0 of each half is the upper field
      a_i.src[N-1-k] = w_buf[k][`GAT_DATA_W-1:0];
      a_i.nbr[N-1-k] = w_buf[N+k][`GAT_DATA_W-1:0];
    end
    a_load_i = 1'b1;
    next_cycle();
    a_load_i = 1'b0;
  endtask

  task automatic stream_rows(input bit with_pops);
    while (row_q.size() > 0) begin
      wh_i     = row_q.pop_front();
      wh_vld_i = 1'b1;
      pop_i    = with_pops && ($urandom % 3 == 0);
      next_cycle();
    end
    wh_vld_i = 1'b0;
    pop_i    = 1'b0;
  endtask

  task automatic drain_fifo();
    int cycles;
    cycles = 0;
    while (pop_cnt < exp_total && cycles < DRAIN_TIMEOUT) begin
      pop_i = ($urandom % 4 != 0);
      next_cycle();
      cycles++;
    end
    pop_i = 1'b0;
    if (pop_cnt < exp_total) begin
      $display("Timeout after %0d cycles: only %0d of %0d coefficients were popped",
               cycles, pop_cnt, exp_total);
      tb_errors++;
      timed_out = 1'b1;
    end
  endtask

  task automatic check_overflow(input bit expected);
    ovf_exp = expected;
    ovf_chk = 1'b1;
    next_cycle();
    ovf_chk = 1'b0;
  endtask

  task automatic run_phase(input int mode);
    if (mode == 0) begin
      stream_rows(1'b1);
      drain_fifo();
      check_overflow(1'b0);
    end else begin
      stream_rows(1'b0);
      for (int i = 0; i < FILL_LATENCY; i++) begin
        next_cycle();
      end
      check_overflow(1'b1);
      drain_fifo();
    end
  endtask

  // ====================
  // Main sequence
  // ====================

  initial begin : main
    int                    fd;
    int                    n;
    int                    mode;
    int                    flag;
    int                    nn;
    int                    ex;
    int                    f [N];
    string                 line;
    gat_attn_pkg::wh_row_t row;
    clk       = 1'b0;
    rst_n     = 1'b0;
    a_load_i  = 1'b0;
    a_i       = '0;
    wh_vld_i  = 1'b0;
    wh_i      = '0;
    pop_i     = 1'b0;
    ovf_chk   = 1'b0;
    ovf_exp   = 1'b0;
    tb_errors = 0;
    exp_total = 0;
    timed_out = 1'b0;
    void'($urandom(3));
    repeat (10) @(posedge clk);
    #5;
    rst_n = 1'b1;

    fd = $fopen("verif/gat_attn_golden.txt", "r");
    if (fd == 0) begin
      $display("Could not open verif/gat_attn_golden.txt");
      tb_errors++;
    end else begin
      while (!timed_out && $fgets(line, fd) != 0) begin
        if (line.getc(0) == "A") begin
          n = $sscanf(line, "A %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
                      w_buf[0], w_buf[1], w_buf[2], w_buf[3], w_buf[4], w_buf[5],
                      w_buf[6], w_buf[7], w_buf[8], w_buf[9], w_buf[10], w_buf[11],
                      w_buf[12], w_buf[13], w_buf[14], w_buf[15]);
          if (n == 2*N) begin
            load_weights();
          end else begin
            $display("Malformed weight line in golden file: %s", line);
            tb_errors++;
          end
        end else if (line.getc(0) == "R") begin
          n = $sscanf(line, "R %d %d %d %d %d %d %d %d %d %d %d", flag, nn,
                      f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], ex);
          if (n == 11) begin
            row.src_flag = flag[0];
            row.num_node = nn[`GAT_NODE_W-1:0];
            for (int k = 0; k < N; k++) begin
              row.feat[k] = f[k][`GAT_WH_W-1:0];
            end
            row_q.push_back(row);
            if (ex >= 0) begin
              exp_total++;
            end
          end else begin
            $display("Malformed row line in golden file: %s", line);
            tb_errors++;
          end
        end else if (line.getc(0) == "G") begin
          n = $sscanf(line, "G %d", mode);
          if (n == 1) begin
            run_phase(mode);
          end else begin
            $display("Malformed phase line in golden file: %s", line);
            tb_errors++;
          end
        end
      end
      $fclose(fd);
    end

    if (coef_vld_o) begin
      $display("FIFO still holds coefficients after the last phase");
      tb_errors++;
    end
    $display("Errors: checker %0d, testbench %0d; popped %0d of %0d expected coefficients",
             chk_errors, tb_errors, pop_cnt, exp_total);
    if (chk_errors == 0 && tb_errors == 0 && pop_cnt == exp_total) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- gat_attn.f
+incdir+hw
hw/gat_attn_pkg.sv
hw/attn_weight_reg.sv
hw/dot_tree.sv
hw/dmvm.sv
hw/coef_fifo.sv
hw/gat_attn_top.sv
verif/attn_checker.sv
verif/tb_gat_attn.sv

//--- run_sim.sh
#!/bin/sh
# Build the GAT attention testbench with Verilator and run it.
# The run passes only when the simulation output holds the pass line.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_gat_attn -f gat_attn.f \
  || { echo "Verilator build failed"; exit 1; }

out=$(./obj_dir/Vtb_gat_attn)
echo "$out"
echo "$out" | grep -qx "All checks passed" && echo "PASS" || { echo "FAIL"; exit 1; }

//--- verif/gat_attn_golden.txt
# A: source weights w0..w7, then neighbor weights w0..w7 (wk multiplies feature k)
# R: src_flag num_node f0..f7 expected_coef (-1 when the full FIFO drops it)
# G: run the queued rows, 0 = random pops while streaming, 1 = no pops until full
#
# Back-to-back neighborhood of five rows
A 4 1 0 0 0 0 0 0 1 1 1 1 0 0 0 0
R 1 5 100 50 0 0 0 0 0 5 9
R 0 5 0 0 200 100 3 0 0 0 11
R 0 5 10 20 30 40 0 0 0 0 8
R 0 5 -100 0 0 0 0 9 0 0 5
R 0 5 0 0 0 1000 0 0 0 -7 22
G 0
# Two neighborhoods back to back, source sum switches
R 1 3 200 100 0 0 0 0 0 0 18
R 0 3 0 0 64 0 0 0 0 0 15
R 0 3 0 0 0 -64 0 0 0 0 13
R 1 3 600 200 0 0 0 0 0 0 53
R 0 3 0 0 100 0 0 0 0 0 42
R 0 3 0 0 0 200 0 0 0 0 43
G 0
# ReLU, rounding boundary near zero and saturation
R 1 4 -500 0 0 0 0 0 0 0 0
R 0 4 0 0 2000 100 0 0 0 0 1
R 0 4 0 0 2047 16 0 0 0 0 0
R 0 4 0 0 2047 2047 0 0 0 0 32
R 1 3 2047 2047 2047 2047 0 0 0 0 255
R 0 3 -2048 -2048 -2048 -2048 0 0 0 0 31
R 0 3 0 0 0 0 0 0 0 0 159
G 0
# Reloaded weights on the upper features
A 0 0 0 0 0 0 2 -1 -1 0 0 0 1 0 0 3
R 1 4 0 0 0 0 100 0 300 50 12
R 0 4 100 50 0 0 500 0 7 100 19
R 0 4 1000 0 0 0 0 0 0 0 0
R 0 4 0 0 0 0 1000 0 0 600 52
G 0
# Twenty rows into an undrained FIFO, the last four are dropped
R 1 20 0 0 0 0 0 0 64 0 2
R 0 20 0 0 0 0 64 0 0 0 3
R 0 20 0 0 0 0 128 0 0 0 4
R 0 20 0 0 0 0 192 0 0 0 5
R 0 20 0 0 0 0 256 0 0 0 6
R 0 20 0 0 0 0 320 0 0 0 7
R 0 20 0 0 0 0 384 0 0 0 8
R 0 20 0 0 0 0 448 0 0 0 9
R 0 20 0 0 0 0 512 0 0 0 10
R 0 20 0 0 0 0 576 0 0 0 11
R 0 20 0 0 0 0 640 0 0 0 12
R 0 20 0 0 0 0 704 0 0 0 13
R 0 20 0 0 0 0 768 0 0 0 14
R 0 20 0 0 0 0 832 0 0 0 15
R 0 20 0 0 0 0 896 0 0 0 16
R 0 20 0 0 0 0 960 0 0 0 17
R 0 20 0 0 0 0 1024 0 0 0 -1
R 0 20 0 0 0 0 1088 0 0 0 -1
R 0 20 0 0 0 0 1152 0 0 0 -1
R 0 20 0 0 0 0 1216 0 0 0 -1
G 1
